//--- extTrig.f
+incdir+hw
hw/trigRegsPkg.sv
hw/trigCorePkg.sv
hw/trigRegBank.sv
hw/trigEdgeDetect.sv
hw/trigGate.sv
hw/trigDelayLine.sv
hw/extTrigTop.sv
testbench/extTrigTb.sv

//--- build.sh
#!/bin/sh
# compile and run the external trigger testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module extTrigTb -f extTrig.f -o extTrigSim

out=$(./obj_dir/extTrigSim)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"

//--- testbench/extTrigTb.sv
`timescale 1ns/1ps
`include "extTrig_settings.svh"

module extTrigTb
	import trigRegsPkg::*, trigCorePkg::*;
();

	typedef enum {opWrite, opRead, opTrig, opBusy, opStart, opStop, opIdle, opRandDelay} tbOp_e;
	localparam logic [31:0] FromModel = 32'hFFFF_FFFF; // expected value comes from the model
	localparam int WaitLimit = 2000;

	logic clk160, arstN, busyIn, startRun, stopRun;
	logic syncTrig0, syncTrigOut, ledTop, ledBot;
	regBusIn_t busIn;
	regBusOut_t busOut;
	trigWord_t trigWord, trigPhase;

	string tName[$];
	tbOp_e tOp[$];
	int tArg[$];          // register, idle cycles or busy level
	logic [31:0] tVal[$]; // write data or expected read value

	// reference model of the trigger unit
	logic mRunning = 1'b0;
	logic mBusy = 1'b0;
	logic [31:0] mCount = '0;
	logic [31:0] mLimit = `EXTTRIG_DEFAULT_LIMIT;
	logic [4:0] mDelay = '0;
	int mDeadUntil = 0; // first posedge index where an accept is possible

	int cyc = 0; // posedges seen so far
	int errors = 0;
	int checks = 0;
	logic rowBad, timedOut = 1'b0;
	logic [31:0] rng = 32'd70611;
	logic [31:0] got;
	int at;

	extTrigTop dut0 (
		.clk160(clk160), .arstN(arstN), .busIn(busIn), .busOut(busOut),
		.trigWord(trigWord), .busyIn(busyIn), .startRun(startRun), .stopRun(stopRun),
		.syncTrig0(syncTrig0), .syncTrigOut(syncTrigOut), .trigPhase(trigPhase),
		.ledTop(ledTop), .ledBot(ledBot)
	);

	initial begin
		clk160 = 1'b0;
		forever #2 clk160 = ~clk160; // 4 ns period
	end

	always @(posedge clk160) cyc <= cyc + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic void addRow(input string name, input tbOp_e op, input int arg,
			input logic [31:0] val);
		tName.push_back(name);
		tOp.push_back(op);
		tArg.push_back(arg);
		tVal.push_back(val);
	endfunction

	// bit 0 resets, bit 1 starts and bit 2 stops the run as the pins do
	function automatic void modelWrite(input int addr, input logic [31:0] data);
		if (addr == 0) begin
			if (data[0]) begin
				mRunning = 1'b0;
				mCount = '0;
				mDeadUntil = 0;
			end else if (data[1] && !mRunning) begin
				mRunning = 1'b1;
				mCount = '0; // new run
			end else if (data[2])
				mRunning = 1'b0;
		end
		else if (addr == 2)
			mLimit = data;
		else if (addr == 3)
			mDelay = data[4:0];
	endfunction

	function automatic logic [31:0] modelRead(input int addr, input int idx);
		case (addr)
			0: return {30'b0, idx < mDeadUntil, mRunning}; // status view
			1: return mCount;
			2: return mLimit;
			default: return {27'b0, mDelay};
		endcase
	endfunction

	task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			errors++;
			rowBad = 1'b1;
		end
	endtask

	task automatic reportTimeout(input string name, input string what);
		$display("%s: no %s within %0d cycles", name, what, WaitLimit);
		errors++;
		timedOut = 1'b1;
		rowBad = 1'b1;
	endtask

	task automatic writeReg(input string name, input int addr, input logic [31:0] data);
		int n;
		@(negedge clk160);
		busIn.wrCe[addr] = 1'b1;
		busIn.wrData = data;
		@(negedge clk160);
		busIn = '0; // one-cycle enable
		n = 0;
		while (!busOut.wrAck && n < WaitLimit) begin
			@(negedge clk160);
			n++;
		end
		if (!busOut.wrAck)
			reportTimeout(name, "write acknowledge");
		else begin
			modelWrite(addr, data);
			@(negedge clk160);
			checkVal({name, " wrAck width"}, 32'h0, {31'b0, busOut.wrAck}); // single-cycle ack
		end
	endtask

	task automatic readReg(input string name, input int addr, output logic [31:0] data,
			output int idx);
		int n;
		@(negedge clk160);
		idx = cyc + 1; // posedge that captures the status
		busIn.rdCe[addr] = 1'b1;
		@(negedge clk160);
		busIn = '0;
		n = 0;
		while (!busOut.rdAck && n < WaitLimit) begin
			@(negedge clk160);
			n++;
		end
		data = busOut.rdData;
		if (!busOut.rdAck)
			reportTimeout(name, "read acknowledge");
		else begin
			@(negedge clk160);
			checkVal({name, " rdAck width"}, 32'h0, {31'b0, busOut.rdAck});
			checkVal({name, " idle rdData"}, 32'h0, busOut.rdData); // zero outside the ack
		end
	endtask

	// one word with sample 0 high and random phase bits, then a zero word
	task automatic sendTrigger(input string name, input int idleAfter);
		trigWord_t word;
		logic prevTop, prevBot, expAcc, seen;
		int acceptIdx, n;
		rng = xorshift(rng);
		word = {rng[7:1], 1'b1};
		@(negedge clk160);
		acceptIdx = cyc + 1;
		expAcc = mRunning && !mBusy && acceptIdx >= mDeadUntil;
		prevTop = ledTop;
		prevBot = ledBot;
		trigWord = word;
		@(negedge clk160);
		trigWord = '0;
		checkVal({name, " syncTrig0"}, {31'b0, expAcc}, {31'b0, syncTrig0});
		checkVal({name, " ledBot"}, {31'b0, prevBot ^ expAcc}, {31'b0, ledBot});
		checkVal({name, " ledTop"}, {31'b0, ~prevTop}, {31'b0, ledTop}); // every edge
		checkVal({name, " trigPhase"}, {24'b0, word}, {24'b0, trigPhase});
		if (expAcc) begin
			mCount = mCount + 1;
			mDeadUntil = acceptIdx + `EXTTRIG_DEADTIME + 1; // dead for DEADTIME cycles
			if (mCount == mLimit)
				mRunning = 1'b0;
			n = 0;
			while (!syncTrigOut && n < WaitLimit) begin
				@(negedge clk160);
				n++;
			end
			if (!syncTrigOut)
				reportTimeout(name, "delayed trigger");
			else
				checkVal({name, " delay cycles"}, {27'b0, mDelay}, n);
		end else begin
			seen = syncTrigOut;
			for (n = 0; n < mDelay; n++) begin
				@(negedge clk160);
				seen = seen | syncTrigOut;
			end
			checkVal({name, " syncTrigOut"}, 32'h0, {31'b0, seen}); // dropped trigger stays out
		end
		repeat (idleAfter) @(negedge clk160);
	endtask

	task automatic pulsePin(input logic start);
		@(negedge clk160);
		startRun = start;
		stopRun = ~start;
		@(negedge clk160);
		startRun = 1'b0;
		stopRun = 1'b0;
		modelWrite(0, start ? 32'h2 : 32'h4);
	endtask

	initial begin
		arstN = 1'b0;
		busIn = '0;
		trigWord = '0;
		busyIn = 1'b0;
		startRun = 1'b0;
		stopRun = 1'b0;

		addRow("rstCount", opRead, 1, 32'h0);
		addRow("rstLimit", opRead, 2, 32'h40000);
		addRow("rstDelay", opRead, 3, 32'h0);
		addRow("rstStatus", opRead, 0, 32'h0);
		addRow("trigNoRun", opTrig, 4, FromModel);
		addRow("cmdStart", opWrite, 0, 32'h2);
		addRow("trig1", opTrig, 0, FromModel);
		addRow("trigDead", opTrig, 0, FromModel);
		addRow("statDead", opRead, 0, FromModel);
		addRow("waitDead", opIdle, 1100, 32'h0);
		addRow("trig2", opTrig, 1100, FromModel);
		addRow("busyOn", opBusy, 1, 32'h0);
		addRow("trigBusy", opTrig, 4, FromModel);
		addRow("busyOff", opBusy, 0, 32'h0);
		addRow("trig3", opTrig, 1100, FromModel);
		addRow("count3", opRead, 1, FromModel);
		for (int k = 0; k < 3; k++) begin
			addRow("randDelay", opRandDelay, 3, 32'h0);
			addRow("delayTrig", opTrig, 1100, FromModel);
		end
		addRow("delayRead", opRead, 3, FromModel);
		addRow("limit3", opWrite, 2, 32'h3);
		addRow("cmdReset", opWrite, 0, 32'h1);
		addRow("restart", opWrite, 0, 32'h2);
		for (int k = 0; k < 4; k++)
			addRow("limTrig", opTrig, 1100, FromModel); // last one past the limit
		addRow("statLimit", opRead, 0, FromModel);
		addRow("countLimit", opRead, 1, FromModel);
		addRow("pinStart", opStart, 0, 32'h0);
		addRow("pinTrig", opTrig, 1100, FromModel);
		addRow("pinStop", opStop, 0, 32'h0);
		addRow("stopTrig", opTrig, 4, FromModel);
		addRow("cmdReset2", opWrite, 0, 32'h1);
		addRow("countClr", opRead, 1, 32'h0);

		repeat (2) @(posedge clk160);
		@(negedge clk160);
		arstN = 1'b1;

		for (int i = 0; i < tName.size() && !timedOut; i++) begin
			rowBad = 1'b0;
			case (tOp[i])
				opWrite: writeReg(tName[i], tArg[i], tVal[i]);
				opRead: begin
					readReg(tName[i], tArg[i], got, at);
					checkVal({tName[i], " rdData"},
						(tVal[i] == FromModel) ? modelRead(tArg[i], at) : tVal[i], got);
				end
				opTrig: sendTrigger(tName[i], tArg[i]);
				opBusy: begin
					@(negedge clk160);
					busyIn = tArg[i][0];
					mBusy = tArg[i][0]; // registered before the next trigger
				end
				opStart: pulsePin(1'b1);
				opStop: pulsePin(1'b0);
				opIdle: repeat (tArg[i]) @(negedge clk160);
				default: begin
					rng = xorshift(rng);
					writeReg(tName[i], 3, {27'b0, rng[4:0]});
				end
			endcase
			$display("%s %s", tName[i], rowBad ? "mismatch" : "ok");
		end

		$display("%0d tests, %0d checks, %0d errors", tName.size(), checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- hw/extTrigTop.sv
`timescale 1ns/1ps
`include "extTrig_settings.svh"

module extTrigTop
	import trigRegsPkg::*, trigCorePkg::*;
(
	input  logic       clk160,
	input  logic       arstN,
	input  regBusIn_t  busIn,
	output regBusOut_t busOut,
	input  trigWord_t  trigWord,    // from the external deserializer
	input  logic       busyIn,
	input  logic       startRun,
	input  logic       stopRun,
	output logic       syncTrig0,   // prompt trigger
	output logic       syncTrigOut, // delayed trigger
	output trigWord_t  trigPhase,
	output logic       ledTop,
	output logic       ledBot
);

	trigCfg_t cfg;
	trigStat_t stat;
	logic trigRise;
	logic accept;

	trigRegBank regBank0 (
		.clk160(clk160), .arstN(arstN),
		.busIn(busIn), .busOut(busOut),
		.cfg(cfg), .stat(stat)
	);

	trigEdgeDetect edgeDetect0 (
		.clk160(clk160), .arstN(arstN),
		.trigWord(trigWord), .trigRise(trigRise),
		.trigPhase(trigPhase), .ledTop(ledTop)
	);

	trigGate gate0 (
		.clk160(clk160), .arstN(arstN),
		.trigRise(trigRise), .busyIn(busyIn),
		.startRun(startRun), .stopRun(stopRun), .cfg(cfg),
		.accept(accept), .syncTrig0(syncTrig0), .ledBot(ledBot), .stat(stat)
	);

	trigDelayLine delayLine0 (
		.clk160(clk160), .arstN(arstN),
		.accept(accept), .delay(cfg.delay), .syncTrigOut(syncTrigOut)
	);

endmodule

//--- hw/trigDelayLine.sv
`timescale 1ns/1ps
`include "extTrig_settings.svh"

module trigDelayLine (
	input  logic                        clk160,
	input  logic                        arstN,
	input  logic                        accept,
	input  logic [`EXTTRIG_DELAY_W-1:0] delay,
	output logic                        syncTrigOut
);

	localparam int Depth = 1 << `EXTTRIG_DELAY_W; // 32 stages

	logic [Depth-1:0] shiftQ; // bit 0 is the newest

	always_ff @(posedge clk160 or negedge arstN) begin
		if (!arstN)
			shiftQ <= '0; // drops anything in flight
		else
			shiftQ <= {shiftQ[Depth-2:0], accept}; // always shifting
	end

	// tap moves with delay, pulses already inside follow the new tap
	assign syncTrigOut = shiftQ[delay]; // delay+1 cycles after accept

endmodule

//--- hw/trigGate.sv
`timescale 1ns/1ps
`include "extTrig_settings.svh"

module trigGate
	import trigCorePkg::*;
(
	input  logic      clk160,
	input  logic      arstN,
	input  logic      trigRise,
	input  logic      busyIn,
	input  logic      startRun,
	input  logic      stopRun,
	input  trigCfg_t  cfg,
	output logic      accept,
	output logic      syncTrig0,
	output logic      ledBot,
	output trigStat_t stat
);

	localparam int DeadTime = `EXTTRIG_DEADTIME;
	localparam int CntW = $clog2(DeadTime + 1);

	logic busyQ;          // busy sampled once
	logic running;
	logic dead;
	logic [CntW-1:0] deadCnt;
	logic [`EXTTRIG_DATA_W-1:0] count;
	logic startReq, stopReq;

	assign startReq = startRun | cfg.cmdStart; // pin or register
	assign stopReq = stopRun | cfg.cmdStop;

	assign accept = trigRise & ~busyQ & ~dead & running;

	always_ff @(posedge clk160 or negedge arstN) begin
		if (!arstN) begin
			busyQ <= 1'b0;
			syncTrig0 <= 1'b0;
			ledBot <= 1'b0;
		end else begin
			busyQ <= busyIn;
			syncTrig0 <= accept; // prompt copy
			if (accept)
				ledBot <= ~ledBot;
		end
	end

	// run state and trigger count
	always_ff @(posedge clk160 or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			count <= '0;
		end else if (cfg.cmdReset) begin
			running <= 1'b0;
			count <= '0;
		end else if (startReq && !running) begin
			running <= 1'b1;
			count <= '0; // fresh run
		end else begin
			if (stopReq || count == cfg.limit)
				running <= 1'b0;
			if (accept)
				count <= count + 1'b1; // only while running
		end
	end

	// dead time, counted from the accept cycle
	always_ff @(posedge clk160 or negedge arstN) begin
		if (!arstN) begin
			dead <= 1'b0;
			deadCnt <= '0;
		end else if (cfg.cmdReset) begin
			dead <= 1'b0;
			deadCnt <= '0;
		end else if (accept) begin
			dead <= 1'b1;
			deadCnt <= '0;
		end else if (dead) begin
			deadCnt <= deadCnt + 1'b1;
			if (deadCnt == CntW'(DeadTime - 1))
				dead <= 1'b0; // high for DeadTime cycles after accept
		end
	end

	always_comb begin
		stat.running = running;
		stat.dead = dead;
		stat.count = count;
	end

endmodule

//--- hw/trigEdgeDetect.sv
`timescale 1ns/1ps
`include "extTrig_settings.svh"

module trigEdgeDetect
	import trigCorePkg::*;
(
	input  logic      clk160,
	input  logic      arstN,
	input  trigWord_t trigWord,
	output logic      trigRise,
	output trigWord_t trigPhase,
	output logic      ledTop
);

	logic sample0Prev; // sample 0 of the last word

	// only sample 0 decides the edge, the rest of the word is phase info
	assign trigRise = trigWord[0] & ~sample0Prev;

	always_ff @(posedge clk160 or negedge arstN) begin
		if (!arstN) begin
			sample0Prev <= 1'b0;
			trigPhase <= '0;
			ledTop <= 1'b0;
		end else begin
			sample0Prev <= trigWord[0];
			trigPhase <= trigWord; // raw word, one cycle late
			if (trigRise)
				ledTop <= ~ledTop; // every edge, accepted or not
		end
	end

endmodule

//--- hw/trigRegBank.sv
`timescale 1ns/1ps
`include "extTrig_settings.svh"

module trigRegBank
	import trigRegsPkg::*, trigCorePkg::*;
(
	input  logic       clk160,
	input  logic       arstN,
	input  regBusIn_t  busIn,
	output regBusOut_t busOut,
	output trigCfg_t   cfg,
	input  trigStat_t  stat
);

	ctrlWord_u wrWord; // incoming data seen as a command
	ctrlWord_u rdCtrl; // register 0 as status
	logic [`EXTTRIG_DATA_W-1:0] limitQ;
	logic [`EXTTRIG_DELAY_W-1:0] delayQ;
	logic [`EXTTRIG_DATA_W-1:0] rdNext;
	logic cmdResetQ, cmdStartQ, cmdStopQ;

	assign wrWord = busIn.wrData;

	always_comb begin
		rdCtrl = '0;
		rdCtrl.status.running = stat.running;
		rdCtrl.status.dead = stat.dead;
	end

	// read mux, stays zero with no enable so rdData is clean outside rdAck
	always_comb begin
		rdNext = '0;
		if (busIn.rdCe[regCtrl])
			rdNext = rdCtrl;
		if (busIn.rdCe[regCount])
			rdNext = stat.count;
		if (busIn.rdCe[regLimit])
			rdNext = limitQ;
		if (busIn.rdCe[regDelay])
			rdNext[`EXTTRIG_DELAY_W-1:0] = delayQ; // upper bits read zero
	end

	always_ff @(posedge clk160 or negedge arstN) begin
		if (!arstN) begin
			limitQ <= `EXTTRIG_DEFAULT_LIMIT;
			delayQ <= '0;
			cmdResetQ <= 1'b0;
			cmdStartQ <= 1'b0;
			cmdStopQ <= 1'b0;
			busOut <= '0;
		end else begin
			busOut.wrAck <= |busIn.wrCe; // count register write is acked, no effect
			busOut.rdAck <= |busIn.rdCe;
			busOut.rdData <= rdNext;

			// command bits only live for the ack cycle
			cmdResetQ <= busIn.wrCe[regCtrl] & wrWord.cmd.reset;
			cmdStartQ <= busIn.wrCe[regCtrl] & wrWord.cmd.startRun;
			cmdStopQ <= busIn.wrCe[regCtrl] & wrWord.cmd.stopRun;

			if (busIn.wrCe[regLimit])
				limitQ <= busIn.wrData;
			if (busIn.wrCe[regDelay])
				delayQ <= busIn.wrData[`EXTTRIG_DELAY_W-1:0];
		end
	end

	always_comb begin
		cfg.cmdReset = cmdResetQ;
		cfg.cmdStart = cmdStartQ;
		cfg.cmdStop = cmdStopQ;
		cfg.limit = limitQ;
		cfg.delay = delayQ;
	end

endmodule

//--- hw/trigCorePkg.sv
`include "extTrig_settings.svh"

package trigCorePkg;

	// one clk160 cycle of deserialized trigger input, bit 0 is the earliest sample
	typedef logic [7:0] trigWord_t;

	// register bank to trigger path
	typedef struct packed {
		logic                        cmdReset; // single-cycle strobe
		logic                        cmdStart; // single-cycle strobe
		logic                        cmdStop;  // single-cycle strobe
		logic [`EXTTRIG_DATA_W-1:0]  limit;    // accepted triggers per run
		logic [`EXTTRIG_DELAY_W-1:0] delay;    // extra cycles for syncTrigOut
	} trigCfg_t;

	// trigger path back to the register bank
	typedef struct packed {
		logic                       running;
		logic                       dead;
		logic [`EXTTRIG_DATA_W-1:0] count; // accepted in this run
	} trigStat_t;

endpackage

//--- hw/trigRegsPkg.sv
`include "extTrig_settings.svh"

package trigRegsPkg;

	// master to slave, one-hot chip enables
	typedef struct packed {
		logic [`EXTTRIG_N_REG-1:0]  rdCe;   // one bit per register
		logic [`EXTTRIG_N_REG-1:0]  wrCe;
		logic [`EXTTRIG_DATA_W-1:0] wrData;
	} regBusIn_t;

	// slave to master
	typedef struct packed {
		logic [`EXTTRIG_DATA_W-1:0] rdData; // zero unless rdAck
		logic                       rdAck;
		logic                       wrAck;
	} regBusOut_t;

	// register 0 as written by software
	typedef struct packed {
		logic [`EXTTRIG_DATA_W-4:0] pad;
		logic                       stopRun;
		logic                       startRun;
		logic                       reset;    // clears run, dead time and count
	} ctrlCmd_t;

	// register 0 as read back
	typedef struct packed {
		logic [`EXTTRIG_DATA_W-3:0] pad;
		logic                       dead;
		logic                       running;
	} ctrlStat_t;

	// same address, different meaning for write and read
	typedef union packed {
		ctrlCmd_t  cmd;
		ctrlStat_t status;
	} ctrlWord_u;

	typedef enum logic [$clog2(`EXTTRIG_N_REG)-1:0] {
		regCtrl  = 0,
		regCount = 1, // read only
		regLimit = 2,
		regDelay = 3
	} regIdx_e;

endpackage

//--- hw/extTrig_settings.svh
`ifndef EXTTRIG_SETTINGS_SVH
`define EXTTRIG_SETTINGS_SVH

// register bus geometry
`define EXTTRIG_N_REG 4
`define EXTTRIG_DATA_W 32

// delay line tap select, 2**width stages
`define EXTTRIG_DELAY_W 5

// trigger path timing
`define EXTTRIG_DEADTIME 1024        // clk160 cycles blocked after an accept
`define EXTTRIG_DEFAULT_LIMIT 32'h40000 // run ends at this many triggers

`endif
